// ==== include/slab_params.svh ====
//------------------------------
// slab allocator parameters
// block and page geometry, pool placement,
// class queue sizing and address width
//------------------------------
`ifndef SLAB_PARAMS_SVH
`define SLAB_PARAMS_SVH

// geometry of one block and one page
`define SLAB_BLOCK_BYTES 64
`define SLAB_PAGE_BLOCKS 32

// page pool handed to class 0 after reset
`define SLAB_POOL_PAGES 8
`define SLAB_POOL_BASE 4096

// class queue sizing where class 0 holds whole pages
`define SLAB_QUEUE_DEPTH 16
`define SLAB_CLASS_COUNT 5

`define SLAB_ADDR_W 32

`endif

// ==== src/mem_layout_pkg.sv ====
//------------------------------
// memory layout types
// class index, free-pointer entry, size classification
// and the byte count to class mapping
//------------------------------
`include "slab_params.svh"

package mem_layout_pkg;

    localparam int MAX_CLASS = `SLAB_CLASS_COUNT - 1;

    typedef logic [2:0] class_idx_t;

    typedef struct packed {
        logic [15:0]             blocks;
        logic [`SLAB_ADDR_W-1:0] addr;
    } blk_entry_t;

    typedef struct packed {
        class_idx_t  cls;
        logic [15:0] blocks;
        logic        oversize;
    } size_class_t;

    // smallest class whose 2^(k-1) blocks hold the size
    // zero bytes counts as oversize
    function automatic size_class_t classify_size(input logic [15:0] size);
        size_class_t sc;
        sc.cls = '0;
        sc.blocks = '0;
        sc.oversize = 1'b1;
        for (int k = MAX_CLASS; k >= 1; k--) begin
            if (size != 16'd0 && size <= (`SLAB_BLOCK_BYTES << (k - 1))) begin
                sc.cls = class_idx_t'(k);
                sc.blocks = 16'(1 << (k - 1));
                sc.oversize = 1'b0;
            end
        end
        return sc;
    endfunction

endpackage

// ==== src/queue_msg_pkg.sv ====
//------------------------------
// queue bank messages
// request from an engine and the
// bank's answer to it
//------------------------------
package queue_msg_pkg;

    // pop = 1 takes the head entry, pop = 0 appends entry
    typedef struct packed {
        logic                       valid;
        logic                       pop;
        mem_layout_pkg::class_idx_t cls;
        mem_layout_pkg::blk_entry_t entry;
    } queue_req_t;

    // done pulses one cycle after the request was served
    typedef struct packed {
        logic                       done;
        // pop found the queue empty
        logic                       empty;
        // push was dropped
        logic                       full;
        mem_layout_pkg::blk_entry_t entry;
    } queue_rsp_t;

endpackage

// ==== src/class_queue_bank.sv ====
//------------------------------
// class queue bank
// five FIFOs of free-pointer entries,
// page loading into class 0 after reset,
// fixed priority between the two engines
//------------------------------
`timescale 1ns/1ps
`include "slab_params.svh"

module class_queue_bank (
    input  logic                     clk,
    input  logic                     rst,
    input  queue_msg_pkg::queue_req_t alloc_req,
    input  queue_msg_pkg::queue_req_t rel_req,
    output queue_msg_pkg::queue_rsp_t alloc_rsp,
    output queue_msg_pkg::queue_rsp_t rel_rsp,
    output logic                     error_overflow
);

    localparam int PTR_W = $clog2(`SLAB_QUEUE_DEPTH);
    localparam int INIT_W = $clog2(`SLAB_POOL_PAGES) + 1;
    localparam logic [PTR_W:0] DEPTH_CNT = `SLAB_QUEUE_DEPTH;
    localparam logic [INIT_W-1:0] INIT_LAST = `SLAB_POOL_PAGES;
    localparam logic [`SLAB_ADDR_W-1:0] PAGE_BYTES = `SLAB_PAGE_BLOCKS * `SLAB_BLOCK_BYTES;
    localparam logic [`SLAB_ADDR_W-1:0] POOL_BASE = `SLAB_POOL_BASE;

    logic [INIT_W-1:0] init_cnt;
    logic init_busy;

    logic sel_alloc;
    logic sel_rel;
    logic op_go;
    queue_msg_pkg::queue_req_t op;
    queue_msg_pkg::queue_rsp_t rsp_next;

    logic [`SLAB_CLASS_COUNT-1:0] push_en;
    logic [`SLAB_CLASS_COUNT-1:0] pop_en;
    logic [`SLAB_CLASS_COUNT-1:0] q_full;
    logic [`SLAB_CLASS_COUNT-1:0] q_empty;
    mem_layout_pkg::blk_entry_t q_front [`SLAB_CLASS_COUNT];
    mem_layout_pkg::blk_entry_t wr_entry;

    // ------------------------------
    // arbitration
    // ------------------------------
    assign init_busy = init_cnt != INIT_LAST;

    // a request whose done is showing is still raised but already served
    assign sel_alloc = !init_busy && alloc_req.valid && !alloc_rsp.done;
    assign sel_rel = !init_busy && !sel_alloc && rel_req.valid && !rel_rsp.done;
    assign op_go = sel_alloc || sel_rel;
    assign op = sel_alloc ? alloc_req : rel_req;

    always_comb begin
        push_en = '0;
        pop_en = '0;
        wr_entry = op.entry;
        if (init_busy) begin
            push_en[0] = 1'b1;
            wr_entry.blocks = 16'(`SLAB_PAGE_BLOCKS);
            wr_entry.addr = POOL_BASE + `SLAB_ADDR_W'(init_cnt) * PAGE_BYTES;
        end else if (op_go) begin
            if (op.pop)
                pop_en[op.cls] = !q_empty[op.cls];
            else
                push_en[op.cls] = !q_full[op.cls];
        end
    end

    always_comb begin
        rsp_next.done = 1'b1;
        rsp_next.empty = op.pop && q_empty[op.cls];
        rsp_next.full = !op.pop && q_full[op.cls];
        rsp_next.entry = q_front[op.cls];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            init_cnt <= '0;
            alloc_rsp <= '0;
            rel_rsp <= '0;
            error_overflow <= 1'b0;
        end else begin
            if (init_busy)
                init_cnt <= init_cnt + 1'b1;
            alloc_rsp <= sel_alloc ? rsp_next : '0;
            rel_rsp <= sel_rel ? rsp_next : '0;
            error_overflow <= op_go && rsp_next.full;
        end
    end

    // ------------------------------
    // per-class circular queues
    // ------------------------------
    for (genvar k = 0; k < `SLAB_CLASS_COUNT; k++) begin : g_queue
        mem_layout_pkg::blk_entry_t mem [`SLAB_QUEUE_DEPTH];
        logic [PTR_W-1:0] head;
        logic [PTR_W-1:0] tail;
        logic [PTR_W:0] count;

        assign q_full[k] = count == DEPTH_CNT;
        assign q_empty[k] = count == '0;
        assign q_front[k] = mem[head];

        always_ff @(posedge clk) begin
            if (push_en[k])
                mem[tail] <= wr_entry;
        end

        // at most one of push and pop per cycle
        always_ff @(posedge clk) begin
            if (rst) begin
                head <= '0;
                tail <= '0;
                count <= '0;
            end else if (push_en[k]) begin
                tail <= tail + 1'b1;
                count <= count + 1'b1;
            end else if (pop_en[k]) begin
                head <= head + 1'b1;
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== src/alloc_engine.sv ====
//------------------------------
// allocation engine
// classifies a request, pops its class or a page,
// returns the address and pushes the remainder back
//------------------------------
`timescale 1ns/1ps
`include "slab_params.svh"

module alloc_engine (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [15:0]              req_size,
    input  logic                     req_valid,
    output logic                     req_ready,
    output logic [`SLAB_ADDR_W-1:0]  malloc_pointer,
    output logic                     malloc_failed,
    output logic                     malloc_valid,
    input  logic                     malloc_ready,
    output queue_msg_pkg::queue_req_t alloc_req,
    input  queue_msg_pkg::queue_rsp_t alloc_rsp
);

    localparam int ADDR_W = `SLAB_ADDR_W;
    localparam int BLK_SHIFT = $clog2(`SLAB_BLOCK_BYTES);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DECIDE,
        ST_POP,
        ST_RESULT,
        ST_PUSH_REM
    } state_t;

    state_t state;
    mem_layout_pkg::size_class_t sc;
    mem_layout_pkg::blk_entry_t popped;
    logic has_rem;

    assign has_rem = !malloc_failed && (popped.blocks > sc.blocks);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            req_ready <= 1'b1;
            malloc_valid <= 1'b0;
            malloc_failed <= 1'b0;
            alloc_req.valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_valid && req_ready) begin
                        sc <= mem_layout_pkg::classify_size(req_size);
                        req_ready <= 1'b0;
                        state <= ST_DECIDE;
                    end
                end
                ST_DECIDE: begin
                    if (sc.oversize) begin
                        malloc_pointer <= '0;
                        malloc_failed <= 1'b1;
                        malloc_valid <= 1'b1;
                        state <= ST_RESULT;
                    end else begin
                        alloc_req.valid <= 1'b1;
                        alloc_req.pop <= 1'b1;
                        alloc_req.cls <= sc.cls;
                        alloc_req.entry <= '0;
                        state <= ST_POP;
                    end
                end
                ST_POP: begin
                    if (alloc_rsp.done) begin
                        if (!alloc_rsp.empty) begin
                            malloc_pointer <= alloc_rsp.entry.addr;
                            malloc_failed <= 1'b0;
                            malloc_valid <= 1'b1;
                            popped <= alloc_rsp.entry;
                            alloc_req.valid <= 1'b0;
                            state <= ST_RESULT;
                        end else if (alloc_req.cls != '0) begin
                            // class ran dry, fall back to a whole page
                            alloc_req.cls <= '0;
                        end else begin
                            malloc_pointer <= '0;
                            malloc_failed <= 1'b1;
                            malloc_valid <= 1'b1;
                            alloc_req.valid <= 1'b0;
                            state <= ST_RESULT;
                        end
                    end
                end
                ST_RESULT: begin
                    if (malloc_ready) begin
                        malloc_valid <= 1'b0;
                        malloc_failed <= 1'b0;
                        if (has_rem) begin
                            alloc_req.valid <= 1'b1;
                            alloc_req.pop <= 1'b0;
                            alloc_req.cls <= sc.cls;
                            alloc_req.entry.blocks <= popped.blocks - sc.blocks;
                            alloc_req.entry.addr <= popped.addr + (ADDR_W'(sc.blocks) << BLK_SHIFT);
                            state <= ST_PUSH_REM;
                        end else begin
                            req_ready <= 1'b1;
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_PUSH_REM: begin
                    if (alloc_rsp.done) begin
                        alloc_req.valid <= 1'b0;
                        req_ready <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== src/release_engine.sv ====
//------------------------------
// release engine
// latches a freed pointer and pushes it
// into the queue of its size class
//------------------------------
`timescale 1ns/1ps
`include "slab_params.svh"

module release_engine (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`SLAB_ADDR_W-1:0]  free_pointer,
    input  logic [15:0]              free_size,
    input  logic                     free_valid,
    output logic                     free_ready,
    output queue_msg_pkg::queue_req_t rel_req,
    input  queue_msg_pkg::queue_rsp_t rel_rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PUSH,
        ST_SKIP
    } state_t;

    state_t state;
    mem_layout_pkg::size_class_t free_sc;

    assign free_sc = mem_layout_pkg::classify_size(free_size);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            free_ready <= 1'b1;
            rel_req.valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (free_valid && free_ready) begin
                        free_ready <= 1'b0;
                        if (free_sc.oversize) begin
                            state <= ST_SKIP;
                        end else begin
                            rel_req.valid <= 1'b1;
                            rel_req.pop <= 1'b0;
                            rel_req.cls <= free_sc.cls;
                            rel_req.entry.blocks <= free_sc.blocks;
                            rel_req.entry.addr <= free_pointer;
                            state <= ST_PUSH;
                        end
                    end
                end
                ST_PUSH: begin
                    // a dropped push is flagged by the bank, nothing to retry
                    if (rel_rsp.done) begin
                        rel_req.valid <= 1'b0;
                        free_ready <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                ST_SKIP: begin
                    free_ready <= 1'b1;
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== src/slab_alloc_top.sv ====
//------------------------------
// slab allocator top level
// allocation and release engines
// sharing one class queue bank
//------------------------------
`timescale 1ns/1ps
`include "slab_params.svh"

module slab_alloc_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [15:0]             req_size,
    input  logic                    req_valid,
    output logic                    req_ready,
    output logic [`SLAB_ADDR_W-1:0] malloc_pointer,
    output logic                    malloc_failed,
    output logic                    malloc_valid,
    input  logic                    malloc_ready,
    input  logic [`SLAB_ADDR_W-1:0] free_pointer,
    input  logic [15:0]             free_size,
    input  logic                    free_valid,
    output logic                    free_ready,
    output logic                    error_overflow
);

    queue_msg_pkg::queue_req_t alloc_req;
    queue_msg_pkg::queue_req_t rel_req;
    queue_msg_pkg::queue_rsp_t alloc_rsp;
    queue_msg_pkg::queue_rsp_t rel_rsp;

    alloc_engine u_alloc (
        .clk            (clk),
        .rst            (rst),
        .req_size       (req_size),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .malloc_pointer (malloc_pointer),
        .malloc_failed  (malloc_failed),
        .malloc_valid   (malloc_valid),
        .malloc_ready   (malloc_ready),
        .alloc_req      (alloc_req),
        .alloc_rsp      (alloc_rsp)
    );

    release_engine u_release (
        .clk          (clk),
        .rst          (rst),
        .free_pointer (free_pointer),
        .free_size    (free_size),
        .free_valid   (free_valid),
        .free_ready   (free_ready),
        .rel_req      (rel_req),
        .rel_rsp      (rel_rsp)
    );

    class_queue_bank u_bank (
        .clk            (clk),
        .rst            (rst),
        .alloc_req      (alloc_req),
        .rel_req        (rel_req),
        .alloc_rsp      (alloc_rsp),
        .rel_rsp        (rel_rsp),
        .error_overflow (error_overflow)
    );

endmodule

// ==== verif/slab_alloc_sva.sv ====
//------------------------------
// malloc port assertions
// valid hold, result stability,
// pointer alignment and pool range
//------------------------------
`timescale 1ns/1ps
`include "slab_params.svh"

module slab_alloc_sva (
    input logic                    clk,
    input logic                    rst,
    input logic                    malloc_valid,
    input logic                    malloc_ready,
    input logic                    malloc_failed,
    input logic [`SLAB_ADDR_W-1:0] malloc_pointer
);

    localparam logic [`SLAB_ADDR_W-1:0] POOL_LO = `SLAB_POOL_BASE;
    localparam logic [`SLAB_ADDR_W-1:0] POOL_HI = `SLAB_POOL_BASE
        + `SLAB_POOL_PAGES * `SLAB_PAGE_BLOCKS * `SLAB_BLOCK_BYTES;

    a_valid_hold: assert property (@(posedge clk) disable iff (rst)
        malloc_valid && !malloc_ready |=> malloc_valid)
        else $error("malloc_valid dropped before malloc_ready");

    a_result_stable: assert property (@(posedge clk) disable iff (rst)
        malloc_valid && !malloc_ready |=> $stable(malloc_pointer) && $stable(malloc_failed))
        else $error("malloc result changed while waiting for malloc_ready");

    // block aligned and inside the page pool
    a_ptr_in_pool: assert property (@(posedge clk) disable iff (rst)
        malloc_valid && !malloc_failed |->
            (malloc_pointer % `SLAB_BLOCK_BYTES == 0)
            && malloc_pointer >= POOL_LO && malloc_pointer < POOL_HI)
        else $error("malloc pointer outside the pool or not block aligned");

endmodule

bind slab_alloc_top slab_alloc_sva sva_i (
    .clk            (clk),
    .rst            (rst),
    .malloc_valid   (malloc_valid),
    .malloc_ready   (malloc_ready),
    .malloc_failed  (malloc_failed),
    .malloc_pointer (malloc_pointer)
);

// ==== verif/slab_alloc_tb.sv ====
//------------------------------
// slab allocator testbench
// clock, reset, directed and random operations,
// queue model, result compare, timeout
//------------------------------
`timescale 1ns/1ps
`include "slab_params.svh"

module slab_alloc_tb;

    localparam int OP_COUNT = 300;
    localparam int CYCLE_LIMIT = 40 * OP_COUNT + 200;
    localparam int DEPTH = `SLAB_QUEUE_DEPTH;

    logic clk;
    logic rst;
    logic [15:0] req_size;
    logic req_valid;
    logic req_ready;
    logic [`SLAB_ADDR_W-1:0] malloc_pointer;
    logic malloc_failed;
    logic malloc_valid;
    logic malloc_ready;
    logic [`SLAB_ADDR_W-1:0] free_pointer;
    logic [15:0] free_size;
    logic free_valid;
    logic free_ready;
    logic error_overflow;

    int seed = 21;
    int cycle_cnt = 0;
    int overflow_cnt = 0;
    int model_drops = 0;
    bit stall_en = 1'b0;
    logic model_failed_last;
    logic [31:0] last_ptr;
    logic last_failed;

    // model of the five class queues
    mem_layout_pkg::blk_entry_t mq [`SLAB_CLASS_COUNT][DEPTH];
    int mq_head [`SLAB_CLASS_COUNT];
    int mq_cnt [`SLAB_CLASS_COUNT];

    logic [31:0] exp_ptr_q[$];
    logic exp_fail_q[$];
    logic [31:0] held_ptr[$];
    logic [15:0] held_size[$];

    slab_alloc_top dut_i (.*);

    always #20 clk = ~clk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, what, got, exp);
            $display("test failed");
            $fatal(1, "mismatch");
        end
    endtask

    // ------------------------------
    // reference model
    // ------------------------------
    // class k from 1 to 4 holds 64 << (k-1) bytes and 0 marks oversize
    function automatic int size_class(input logic [15:0] size);
        if (size == 16'd0 || size > (`SLAB_BLOCK_BYTES << (`SLAB_CLASS_COUNT - 2)))
            return 0;
        for (int k = 1; k < `SLAB_CLASS_COUNT; k++) begin
            if (size <= (`SLAB_BLOCK_BYTES << (k - 1)))
                return k;
        end
        return 0;
    endfunction

    function automatic void model_push(input int cls, input logic [15:0] blocks,
                                       input logic [31:0] addr);
        if (mq_cnt[cls] == DEPTH) begin
            model_drops++;
        end else begin
            mq[cls][(mq_head[cls] + mq_cnt[cls]) % DEPTH] = {blocks, addr};
            mq_cnt[cls]++;
        end
    endfunction

    function automatic bit model_pop(input int cls, output mem_layout_pkg::blk_entry_t e);
        e = '0;
        if (mq_cnt[cls] == 0)
            return 1'b0;
        e = mq[cls][mq_head[cls]];
        mq_head[cls] = (mq_head[cls] + 1) % DEPTH;
        mq_cnt[cls]--;
        return 1'b1;
    endfunction

    function automatic void model_alloc(input logic [15:0] size, output logic [31:0] ptr,
                                        output logic failed);
        int cls;
        logic [15:0] need;
        bit got;
        mem_layout_pkg::blk_entry_t e;
        cls = size_class(size);
        ptr = '0;
        failed = 1'b1;
        if (cls == 0)
            return;
        need = 16'(1 << (cls - 1));
        got = model_pop(cls, e);
        // empty class falls back to a whole page
        if (!got)
            got = model_pop(0, e);
        if (!got)
            return;
        ptr = e.addr;
        failed = 1'b0;
        if (e.blocks > need)
            model_push(cls, e.blocks - need, e.addr + 32'(need) * `SLAB_BLOCK_BYTES);
    endfunction

    function automatic void model_free(input logic [31:0] ptr, input logic [15:0] size);
        int cls;
        cls = size_class(size);
        if (cls != 0)
            model_push(cls, 16'(1 << (cls - 1)), ptr);
    endfunction

    // ------------------------------
    // operations
    // ------------------------------
    task automatic do_alloc(input logic [15:0] size);
        logic [31:0] ep;
        logic ef;
        @(posedge clk);
        while (!req_ready)
            @(posedge clk);
        req_size <= size;
        req_valid <= 1'b1;
        model_alloc(size, ep, ef);
        model_failed_last = ef;
        exp_ptr_q.push_back(ep);
        exp_fail_q.push_back(ef);
        if (!ef) begin
            held_ptr.push_back(ep);
            held_size.push_back(size);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        do begin
            @(posedge clk);
            malloc_ready <= stall_en ? 1'($random(seed)) : 1'b1;
        end while (!req_ready);
        malloc_ready <= 1'b1;
    endtask

    task automatic do_free(input logic [31:0] ptr, input logic [15:0] size);
        @(posedge clk);
        while (!free_ready)
            @(posedge clk);
        free_pointer <= ptr;
        free_size <= size;
        free_valid <= 1'b1;
        model_free(ptr, size);
        @(posedge clk);
        free_valid <= 1'b0;
        do
            @(posedge clk);
        while (!free_ready);
    endtask

    // compare every malloc transfer with the model
    always @(posedge clk) begin : compare_results
        logic [31:0] ep;
        logic ef;
        if (!rst && malloc_valid && malloc_ready) begin
            check_value(32'(exp_ptr_q.size() > 0), 32'd1, "malloc result outstanding");
            ep = exp_ptr_q.pop_front();
            ef = exp_fail_q.pop_front();
            check_value(32'(malloc_failed), 32'(ef), "malloc_failed");
            check_value(malloc_pointer, ep, "malloc_pointer");
            last_ptr = malloc_pointer;
            last_failed = malloc_failed;
        end
    end

    always @(posedge clk) begin
        if (!rst && error_overflow)
            overflow_cnt <= overflow_cnt + 1;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int r;
        int idx;
        logic [15:0] rsize;
        logic [31:0] p4a;
        logic [31:0] p4b;
        clk = 1'b0;
        rst = 1'b1;
        req_size = '0;
        req_valid = 1'b0;
        malloc_ready = 1'b1;
        free_pointer = '0;
        free_size = '0;
        free_valid = 1'b0;
        for (int c = 0; c < `SLAB_CLASS_COUNT; c++) begin
            mq_head[c] = 0;
            mq_cnt[c] = 0;
        end
        for (int p = 0; p < `SLAB_POOL_PAGES; p++)
            model_push(0, 16'(`SLAB_PAGE_BLOCKS),
                       `SLAB_POOL_BASE + p * `SLAB_PAGE_BLOCKS * `SLAB_BLOCK_BYTES);
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // first page split into class 1
        do_alloc(16'd64);
        check_value(last_ptr, `SLAB_POOL_BASE, "first 64 byte alloc");
        do_alloc(16'd64);
        check_value(last_ptr, `SLAB_POOL_BASE + 64, "second 64 byte alloc");

        do_alloc(16'd100);
        do_alloc(16'd200);
        // class 4 takes page 3 after classes 2 and 3 took pages 1 and 2
        p4a = `SLAB_POOL_BASE + 3 * `SLAB_PAGE_BLOCKS * `SLAB_BLOCK_BYTES;
        p4b = p4a + 8 * `SLAB_BLOCK_BYTES;
        do_alloc(16'd500);
        check_value(last_ptr, p4a, "500 byte alloc from a new page");
        do_alloc(16'd0);
        do_alloc(16'd600);
        do_alloc(16'd513);

        // drain class 4 so freed pointers come back in FIFO order
        do_alloc(16'd500);
        check_value(last_ptr, p4b, "500 byte alloc from the class 4 remainder");
        do_alloc(16'd500);
        do_alloc(16'd500);
        do_free(p4a, 16'd500);
        do_free(p4b, 16'd480);
        do_alloc(16'd500);
        check_value(last_ptr, p4a, "first reuse of freed pointer");
        do_alloc(16'd450);
        check_value(last_ptr, p4b, "second reuse of freed pointer");
        do_alloc(16'd500);

        stall_en = 1'b1;
        for (int n = 0; n < 200; n++) begin
            r = $random(seed);
            if (held_ptr.size() == 0 || r[1:0] != 2'd0) begin
                rsize = 16'($unsigned($random(seed)) % 600);
                do_alloc(rsize);
            end else begin
                idx = int'($unsigned($random(seed)) % held_ptr.size());
                do_free(held_ptr[idx], held_size[idx]);
                held_ptr.delete(idx);
                held_size.delete(idx);
            end
        end

        // use up class 4 and the remaining pages
        model_failed_last = 1'b0;
        for (int n = 0; n < 80 && !model_failed_last; n++)
            do_alloc(16'd500);
        check_value(32'(last_failed), 32'd1, "pool exhausted");

        repeat (4) @(posedge clk);
        check_value(32'(exp_ptr_q.size()), 32'd0, "results still pending");
        check_value(32'(overflow_cnt), 32'(model_drops), "overflow pulses");
        $display("test passed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+include
src/mem_layout_pkg.sv
src/queue_msg_pkg.sv
src/class_queue_bank.sv
src/alloc_engine.sv
src/release_engine.sv
src/slab_alloc_top.sv
verif/slab_alloc_sva.sv
verif/slab_alloc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the slab allocator testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module slab_alloc_tb -o slab_sim \
    && ./obj_dir/slab_sim 2>&1 | tee sim.log \
    || echo "build or simulation did not complete"

grep -qx "test passed" sim.log 2>/dev/null \
    && echo "simulation result: PASS" \
    || { echo "simulation result: FAIL"; exit 1; }
